//--- rtl/rs_cfg.svh
/*
 * Build-time sizing for the issue subsystem:
 * operand width, ROB tag width and reservation-station depth
 */
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath and tag sizing
////////////////////////////////////////////////////////////////////////////

`define RS_XLEN      32   // Operand and result width
`define RS_TAG_BITS  6    // ROB tag width

// Number of bank slots (2 or more)
`define RS_ENTRIES   4

`endif

//--- rtl/isa_pkg.sv
/*
 * ALU function encoding and shift amount width
 */
`include "rs_cfg.svh"

package isa_pkg;

    // Shift amount taken from the low bits of opb
    localparam int SHAMT_BITS = $clog2(`RS_XLEN);

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,    // Reset value
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,    // Logical left
        ALU_SRL = 4'h6,    // Logical right
        ALU_SLT = 4'h7     // Signed less-than
    } alu_func_t;

endpackage

//--- rtl/ooo_pkg.sv
/*
 * Out-of-order core records: ROB tag, tagged operand,
 * dispatch and issue records, CDB broadcast
 */
`include "rs_cfg.svh"

package ooo_pkg;
    import isa_pkg::*;

    typedef logic [`RS_TAG_BITS-1:0] rob_tag_t;

    // Value when valid, otherwise tag of the producer
    typedef struct packed {
        logic                valid;
        rob_tag_t            tag;
        logic [`RS_XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        alu_func_t           func;
        rob_tag_t            tag;     // Destination
        logic [`RS_XLEN-1:0] npc;
        operand_t            opa;
        operand_t            opb;
    } rs_dispatch_t;

    typedef struct packed {
        alu_func_t           func;
        rob_tag_t            tag;     // Destination
        logic [`RS_XLEN-1:0] npc;
        logic [`RS_XLEN-1:0] opa;
        logic [`RS_XLEN-1:0] opb;
    } rs_issue_t;

    typedef struct packed {
        logic                valid;   // One-cycle pulse
        rob_tag_t            tag;
        logic [`RS_XLEN-1:0] value;
    } cdb_t;

endpackage

//--- rtl/rs_entry.sv
/*
 * Single reservation-station slot
 * Holds one dispatched instruction and snoops the CDB
 * until both operands are valid
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_entry
    import isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         load,       // Allocate this slot
    input  logic         free,       // Issued this cycle
    input  rs_dispatch_t dispatch,
    input  cdb_t         cdb,
    output logic         busy,
    output logic         ready,
    output rs_issue_t    issue
);

    ////////////////////////////////////////////////////////////////////////
    // Slot storage
    ////////////////////////////////////////////////////////////////////////

    alu_func_t           func_q;
    rob_tag_t            dest_q;     // Destination ROB tag
    logic [`RS_XLEN-1:0] npc_q;
    operand_t            opa_q;
    operand_t            opb_q;
    logic                busy_q;     // Slot occupied

    // Pick up a broadcast result for a waiting operand
    function automatic operand_t snoop(operand_t op, cdb_t bus);
        operand_t res;
        res = op;
        if (!op.valid && bus.valid && (bus.tag == op.tag)) begin
            res.valid = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            func_q <= ALU_ADD;
            dest_q <= '0;
            npc_q  <= '0;
            opa_q  <= '0;
            opb_q  <= '0;
            busy_q <= 1'b0;
        end else if (load && !busy_q) begin
            func_q <= dispatch.func;
            dest_q <= dispatch.tag;
            npc_q  <= dispatch.npc;
            opa_q  <= snoop(dispatch.opa, cdb);    // Same-cycle capture
            opb_q  <= snoop(dispatch.opb, cdb);
            busy_q <= 1'b1;
        end else if (free) begin
            // Back to reset contents
            func_q <= ALU_ADD;
            dest_q <= '0;
            npc_q  <= '0;
            opa_q  <= '0;
            opb_q  <= '0;
            busy_q <= 1'b0;
        end else if (busy_q) begin
            opa_q <= snoop(opa_q, cdb);            // Wakeup
            opb_q <= snoop(opb_q, cdb);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Status and issue record
    ////////////////////////////////////////////////////////////////////////

    assign busy  = busy_q;
    assign ready = busy_q && opa_q.valid && opb_q.valid;

    always_comb begin
        issue.func = func_q;
        issue.tag  = dest_q;
        issue.npc  = npc_q;
        issue.opa  = opa_q.value;
        issue.opb  = opb_q.value;
    end

endmodule

//--- rtl/rs_bank.sv
/*
 * Reservation-station bank
 * Lowest-free-slot allocation, lowest-index issue select,
 * full flag and per-slot free pulse
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_bank
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         dispatch_valid,   // One-cycle strobe
    input  rs_dispatch_t dispatch,
    input  cdb_t         cdb,
    output logic         full,
    output logic         issue_valid,
    output rs_issue_t    issue
);

    localparam int IDX_BITS = $clog2(`RS_ENTRIES);

    logic [`RS_ENTRIES-1:0] busy_vec;
    logic [`RS_ENTRIES-1:0] ready_vec;
    logic [`RS_ENTRIES-1:0] load_vec;    // One-hot allocate
    logic [`RS_ENTRIES-1:0] free_vec;    // One-hot issue/free
    rs_issue_t              issue_vec [`RS_ENTRIES];
    logic [IDX_BITS-1:0]    issue_idx;

    ////////////////////////////////////////////////////////////////////////
    // Slots
    ////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_slot
        rs_entry rs_entry_i (
            .clock    (clock),
            .reset    (reset),
            .load     (load_vec[i]),
            .free     (free_vec[i]),
            .dispatch (dispatch),
            .cdb      (cdb),
            .busy     (busy_vec[i]),
            .ready    (ready_vec[i]),
            .issue    (issue_vec[i])
        );
    end

    assign full = &busy_vec;

    // Allocation encoder; scanning downward leaves the lowest free slot
    always_comb begin
        load_vec = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                load_vec    = '0;
                load_vec[i] = 1'b1;
            end
        end
        if (!dispatch_valid) begin
            load_vec = '0;                   // No strobe this cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Issue select
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_idx   = IDX_BITS'(i);  // Lowest ready wins
                issue_valid = 1'b1;
            end
        end
    end

    // Slot leaves the bank on the same edge the ALU registers it
    always_comb begin
        free_vec = '0;
        if (issue_valid) begin
            free_vec[issue_idx] = 1'b1;
        end
    end

    assign issue = issue_vec[issue_idx];

endmodule

//--- rtl/alu_unit.sv
/*
 * Single-cycle integer ALU
 * Registers result and destination tag onto the CDB
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module alu_unit
    import isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    input  rs_issue_t issue,
    output cdb_t      cdb
);

    logic [`RS_XLEN-1:0] result;
    logic [SHAMT_BITS-1:0] shamt;         // Low bits of opb only
    logic                valid_q;
    rob_tag_t            tag_q;
    logic [`RS_XLEN-1:0] value_q;

    assign shamt = issue.opb[SHAMT_BITS-1:0];

    always_comb begin
        case (issue.func)
            ALU_ADD: result = issue.opa + issue.opb;
            ALU_SUB: result = issue.opa - issue.opb;
            ALU_AND: result = issue.opa & issue.opb;
            ALU_OR:  result = issue.opa | issue.opb;
            ALU_XOR: result = issue.opa ^ issue.opb;
            ALU_SLL: result = issue.opa << shamt;
            ALU_SRL: result = issue.opa >> shamt;
            ALU_SLT: result = {{(`RS_XLEN-1){1'b0}},
                               ($signed(issue.opa) < $signed(issue.opb))};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) valid_q <= 1'b0;
        else       valid_q <= issue_valid;   // One-cycle pulse per issue
    end

    always_ff @(posedge clock) begin
        tag_q   <= issue.tag;
        value_q <= result;
    end

    assign cdb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

//--- rtl/rs_issue_top.sv
/*
 * Issue subsystem top level
 * Reservation-station bank feeding the ALU, CDB looped back
 */
`timescale 1ns/1ps

module rs_issue_top
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         dispatch_valid,
    input  rs_dispatch_t dispatch,
    output logic         full,
    output cdb_t         cdb          // Also drives wakeup
);

    logic      issue_valid;
    rs_issue_t issue;

    rs_bank rs_bank_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),        // Result bus back into slots
        .full           (full),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    alu_unit alu_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (cdb)
    );

endmodule

//--- tb/rs_issue_tb.sv
/*
 * Testbench for the issue subsystem
 * Dispatch table with expected results, CDB scoreboard,
 * fixed-latency and full-flag checks, cycle-count timeout
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_issue_tb
    import isa_pkg::*;
    import ooo_pkg::*;
();

    localparam int NUM_ROWS       = 22;
    localparam int NUM_TAGS       = 2 ** `RS_TAG_BITS;
    localparam int TIMEOUT_CYCLES = 10 * NUM_ROWS + 50;
    localparam logic [31:0] LFSR_SEED = 32'hc204_68f4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32+x^22+x^2+x+1

    typedef struct {
        alu_func_t           func;
        rob_tag_t            tag;
        operand_t            opa;
        operand_t            opb;
        bit                  idle;       // Wait for an empty bank first
        bit                  full_exp;   // full high one cycle later
        logic [`RS_XLEN-1:0] expv;
    } row_t;

    logic         clock;
    logic         reset;
    logic         dispatch_valid;
    rs_dispatch_t dispatch;
    logic         full;
    cdb_t         cdb;

    row_t                tbl [NUM_ROWS];
    int                  n_rows = 0;
    logic [`RS_XLEN-1:0] exp_val  [NUM_TAGS];   // Scoreboard
    bit                  pending  [NUM_TAGS];
    bit                  seen     [NUM_TAGS];
    bit                  lat_chk  [NUM_TAGS];
    int                  disp_cyc [NUM_TAGS];
    int                  seen_cyc [NUM_TAGS];
    int                  cyc = 0;
    int                  value_errs = 0;
    int                  other_errs = 0;
    logic [31:0]         lfsr = LFSR_SEED;

    rs_issue_top rs_issue_top_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .full           (full),
        .cdb            (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [`RS_XLEN-1:0] rand_word();
        logic [`RS_XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < `RS_XLEN; i++) begin
            w    = {w[`RS_XLEN-2:0], lfsr[0]};   // One step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return w;
    endfunction

    function automatic operand_t op_value(logic [`RS_XLEN-1:0] v);
        return operand_t'{valid: 1'b1, tag: '0, value: v};
    endfunction

    function automatic operand_t op_tag(int t);
        return operand_t'{valid: 1'b0, tag: rob_tag_t'(t), value: '0};
    endfunction

    function automatic logic [`RS_XLEN-1:0] alu_ref(alu_func_t f,
                                                  logic [`RS_XLEN-1:0] a,
                                                  logic [`RS_XLEN-1:0] b);
        logic [`RS_XLEN-1:0] r;
        r = '0;
        case (f)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << (b % `RS_XLEN);
            ALU_SRL: r = a >> (b % `RS_XLEN);
            ALU_SLT: begin
                if (a[`RS_XLEN-1] != b[`RS_XLEN-1]) r[0] = a[`RS_XLEN-1];  // Negative one is less
                else r[0] = (a < b);
            end
            default: r = 'x;
        endcase
        return r;
    endfunction

    task automatic add_row(alu_func_t f, int t, operand_t a, operand_t b,
                           bit idle, bit full_exp);
        tbl[n_rows] = '{func: f, tag: rob_tag_t'(t), opa: a, opb: b,
                        idle: idle, full_exp: full_exp, expv: '0};
        n_rows++;
    endtask

    task automatic build_table();
        add_row(ALU_ADD,  1, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_SUB,  2, op_value(32'h5), op_value(32'h9), 1, 0);
        add_row(ALU_AND,  3, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_OR,   4, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_XOR,  5, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_SLL,  6, op_value(rand_word()), op_value(32'h25), 1, 0);   // 37 -> 5
        add_row(ALU_SRL,  7, op_value(32'h8000_0000), op_value(32'hffff_ffe3), 1, 0);
        add_row(ALU_SLT,  8, op_value(32'hffff_fff0), op_value(32'h3), 1, 0);
        add_row(ALU_SLT,  9, op_value(32'h5), op_value(32'hffff_ffff), 1, 0);
        add_row(ALU_SLT, 10, op_value(32'hffff_fff9), op_value(32'hffff_fffd), 1, 0);
        // Chain with producers still in flight
        add_row(ALU_ADD, 11, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_SUB, 12, op_tag(11), op_value(rand_word()), 0, 0);
        add_row(ALU_XOR, 13, op_tag(12), op_tag(11), 0, 0);
        add_row(ALU_SLL, 14, op_tag(13), op_value(32'h44), 0, 0);
        // Row 17 lands while tag 15 is on the CDB
        add_row(ALU_OR,  15, op_value(rand_word()), op_value(rand_word()), 1, 0);
        add_row(ALU_AND, 16, op_value(rand_word()), op_value(rand_word()), 0, 0);
        add_row(ALU_SUB, 17, op_tag(15), op_tag(16), 0, 0);
        // Three waiters plus their producer fill the bank
        add_row(ALU_XOR, 41, op_value(rand_word()), op_tag(40), 1, 0);
        add_row(ALU_ADD, 42, op_value(32'd100), op_tag(40), 0, 0);
        add_row(ALU_SRL, 43, op_value(32'hf000_0000), op_tag(40), 0, 0);
        add_row(ALU_SUB, 40, op_value(rand_word()), op_value(rand_word()), 0, 1);
        add_row(ALU_SLT, 44, op_tag(40), op_value(rand_word()), 0, 0);
    endtask

    // Producers always carry lower tags, so one pass in tag order resolves all
    task automatic compute_expected();
        logic [`RS_XLEN-1:0] a;
        logic [`RS_XLEN-1:0] b;
        for (int t = 0; t < NUM_TAGS; t++) begin
            for (int r = 0; r < n_rows; r++) begin
                if (tbl[r].tag == t) begin
                    a = tbl[r].opa.valid ? tbl[r].opa.value : exp_val[tbl[r].opa.tag];
                    b = tbl[r].opb.valid ? tbl[r].opb.value : exp_val[tbl[r].opb.tag];
                    tbl[r].expv = alu_ref(tbl[r].func, a, b);
                    exp_val[t]  = tbl[r].expv;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    task automatic check_cdb(input cdb_t got, input cdb_t exp);
        if (got.valid !== exp.valid) begin
            $display("[FAIL] cdb.valid got %h expected %h", got.valid, exp.valid);
            value_errs++;
        end else if (exp.valid && got.value !== exp.value) begin
            $display("[FAIL] cdb.value tag %h got %h expected %h",
                     got.tag, got.value, exp.value);
            value_errs++;
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] full got %h expected %h", got, exp);
            value_errs++;
        end
    endtask

    function automatic bit any_pending();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Plays the ROB by handing over results already gone by as values
    function automatic operand_t resolve_op(operand_t op);
        operand_t res;
        res = op;
        if (!op.valid && seen[op.tag] && seen_cyc[op.tag] < cyc) begin
            res.valid = 1'b1;
            res.value = exp_val[op.tag];
        end
        return res;
    endfunction

    task automatic apply_row(input int r);
        rs_dispatch_t rec;
        while (tbl[r].idle && any_pending()) @(negedge clock);
        while (full) @(negedge clock);
        rec.func = tbl[r].func;
        rec.tag  = tbl[r].tag;
        rec.npc  = 32'h0000_1000 + 4 * r;
        rec.opa  = resolve_op(tbl[r].opa);
        rec.opb  = resolve_op(tbl[r].opb);
        pending[rec.tag]  = 1'b1;
        disp_cyc[rec.tag] = cyc;
        lat_chk[rec.tag]  = tbl[r].idle && tbl[r].opa.valid && tbl[r].opb.valid;
        dispatch       = rec;
        dispatch_valid = 1'b1;
        @(negedge clock);
        dispatch_valid = 1'b0;
        if (tbl[r].full_exp) check_full(full, 1'b1);
    endtask

    // CDB monitor sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && cdb.valid === 1'b1) begin
            if (seen[cdb.tag]) begin
                $display("Tag %0d was broadcast on cdb a second time", cdb.tag);
                other_errs++;
            end else if (!pending[cdb.tag]) begin
                $display("Unexpected tag %0d on cdb, it was never dispatched", cdb.tag);
                other_errs++;
            end else begin
                check_cdb(cdb, cdb_t'{valid: 1'b1, tag: cdb.tag, value: exp_val[cdb.tag]});
                if (lat_chk[cdb.tag] && (cyc - disp_cyc[cdb.tag]) != 2) begin
                    $display("Tag %0d took %0d cycles from dispatch instead of 2",
                             cdb.tag, cyc - disp_cyc[cdb.tag]);
                    other_errs++;
                end
                pending[cdb.tag]  = 1'b0;
                seen[cdb.tag]     = 1'b1;
                seen_cyc[cdb.tag] = cyc;
            end
        end
    end

    always @(posedge clock) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the table never finished", cyc);
            $display("Errors: %0d value, %0d other", value_errs, other_errs);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        int drain;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        build_table();
        compute_expected();
        repeat (10) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_full(full, 1'b0);                  // Reset state
        check_cdb(cdb, cdb_t'{valid: 1'b0, tag: '0, value: '0});
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        drain = 0;
        while (any_pending() && drain < 4 * `RS_ENTRIES + 20) begin
            @(negedge clock);
            drain++;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) begin
                $display("Tag %0d was dispatched but never came back on cdb", t);
                other_errs++;
            end
        end
        check_full(full, 1'b0);                  // Bank drained
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- rs_issue.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/ooo_pkg.sv
rtl/rs_entry.sv
rtl/rs_bank.sv
rtl/alu_unit.sv
rtl/rs_issue_top.sv
tb/rs_issue_tb.sv

//--- Bender.yml
package:
  name: rs_issue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/ooo_pkg.sv
      - rtl/rs_entry.sv
      - rtl/rs_bank.sv
      - rtl/alu_unit.sv
      - rtl/rs_issue_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/rs_issue_tb.sv
